// File: files.f
src/sccb_pkg.sv
src/sccb_regs_decode.sv
src/sccb_byte_engine.sv
src/sccb_result.sv
src/sccb_master_top.sv
sim/sccb_servant_model.sv
sim/tb_sccb_master.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and decide pass or fail from its output.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_sccb_master -f files.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if grep -qx "No errors" <<< "$out"; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// File: sim/sccb_servant_model.sv
`timescale 1ns/1ps
`default_nettype none

module sccb_servant_model #(
	parameter int         ADDR_BYTES = 2,
	parameter logic [6:0] DEV_ID     = 7'h21 // 0x42 write, 0x43 read
) (
	input  wire clk, // oversampling clock, bus sampled on its falling edge
	input  wire scl,
	inout  wire sda
);

	typedef enum logic [2:0] {
		ph_idle,   // not addressed, waits for a start
		ph_dev,    // receiving the device byte
		ph_addr,   // receiving address bytes
		ph_wdata,  // receiving write data
		ph_rstart, // last address ack in progress, data follows
		ph_rdata,  // sending a read byte
		ph_done    // byte sent, stays off the bus until stop
	} phase_t;

	logic [7:0] mem [256];
	phase_t     phase;
	logic       scl_d;
	logic       sda_d;
	logic       oe;      // pull sda low
	logic       in_ack;  // inside a ninth bit
	logic       rw;
	logic [3:0] bit_cnt;
	logic [7:0] shreg;
	logic [7:0] tx;
	logic [7:0] idx;     // register index, auto increments
	int         addr_left;

	assign sda = oe ? 1'b0 : 1'bz; // open drain

	initial begin
		for (int i = 0; i < 256; i++)
			mem[i] = 8'(i) ^ 8'h5a; // preload pattern
		phase     = ph_idle;
		scl_d     = 1'b1;
		sda_d     = 1'b1;
		oe        = 1'b0;
		in_ack    = 1'b0;
		rw        = 1'b0;
		bit_cnt   = 4'd0;
		shreg     = 8'h00;
		tx        = 8'h00;
		idx       = 8'h00;
		addr_left = 0;
	end

	always @(negedge clk) begin
		if (scl_d && scl && sda_d && !sda && !oe) begin
			phase   <= ph_dev; // start
			bit_cnt <= 4'd0;
			in_ack  <= 1'b0;
		end else if (scl_d && scl && !sda_d && sda && !oe) begin
			phase  <= ph_idle; // stop
			in_ack <= 1'b0;
		end else if (!scl_d && scl) begin
			if (!in_ack && (phase inside {ph_dev, ph_addr, ph_wdata})) begin
				shreg   <= {shreg[6:0], sda}; // msb first
				bit_cnt <= bit_cnt + 4'd1;
			end
		end else if (scl_d && !scl) begin
			if (in_ack) begin
				in_ack  <= 1'b0; // ninth bit over, let go
				oe      <= 1'b0;
				bit_cnt <= 4'd0;
				if (phase == ph_rstart) begin
					tx      <= mem[idx];
					oe      <= !mem[idx][7];
					idx     <= idx + 8'd1;
					bit_cnt <= 4'd1;
					phase   <= ph_rdata;
				end else if (phase == ph_rdata) begin
					phase <= ph_done; // master acks every byte, a stop follows
				end
			end else if (phase == ph_rdata) begin
				if (bit_cnt < 4'd8) begin
					oe      <= !tx[7 - bit_cnt];
					bit_cnt <= bit_cnt + 4'd1;
				end else begin
					oe     <= 1'b0; // master ack slot
					in_ack <= 1'b1;
				end
			end else if (bit_cnt == 4'd8) begin
				bit_cnt <= 4'd0;
				case (phase)
					ph_dev: begin
						if (shreg[7:1] == DEV_ID) begin
							rw        <= shreg[0];
							oe        <= 1'b1;
							in_ack    <= 1'b1;
							addr_left <= ADDR_BYTES;
							phase     <= ph_addr;
						end else begin
							phase <= ph_idle; // other id, no ack
						end
					end
					ph_addr: begin
						idx       <= shreg; // low byte wins
						oe        <= 1'b1;
						in_ack    <= 1'b1;
						addr_left <= addr_left - 1;
						if (addr_left == 1)
							phase <= rw ? ph_rstart : ph_wdata;
					end
					ph_wdata: begin
						mem[idx] <= shreg;
						idx      <= idx + 8'd1;
						oe       <= 1'b1;
						in_ack   <= 1'b1;
					end
					default: begin
					end
				endcase
			end
		end
		scl_d <= scl;
		sda_d <= sda;
	end

endmodule

`default_nettype wire

// File: sim/tb_sccb_master.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sccb_master;

	import sccb_pkg::*;

	localparam int         clk_hz      = 250_000_000;
	localparam int         scl_hz      = 5_000_000;
	localparam int         addr_bytes  = 2;
	localparam int         scl_clks    = clk_hz / scl_hz; // clocks per scl period
	// 4 transactions of 5 bytes, 9 scl periods each, 4 ns clock, x4 margin
	localparam int         watchdog_ns = 4 * 5 * 9 * scl_clks * 4 * 4;
	localparam logic [7:0] dev_wr      = 8'h42;
	localparam logic [7:0] dev_rd      = 8'h43;
	localparam logic [7:0] dev_none    = 8'h50;
	localparam logic [7:0] preload_key = 8'h5a;

	logic                  clk;
	logic                  rst_n;
	logic [axi_addr_w-1:0] awaddr;
	logic                  awvalid;
	logic                  awready;
	logic [axi_data_w-1:0] wdata;
	logic                  wvalid;
	logic                  wready;
	logic                  bvalid;
	logic [1:0]            bresp;
	logic                  bready;
	logic [axi_addr_w-1:0] araddr;
	logic                  arvalid;
	logic                  arready;
	logic                  rvalid;
	logic [axi_data_w-1:0] rdata;
	logic [1:0]            rresp;
	logic                  rready;
	wire                   scl;
	wire                   sda;

	int          errors;
	int          checks;
	logic [31:0] lfsr;
	logic [7:0]  wr_data;    // byte stored at index 0x10 by the write test
	logic [7:0]  tx_bytes[$]; // bytes of the next transaction

	pullup (sda);

	sccb_master_top #(
		.CLK_HZ    (clk_hz),
		.SCL_HZ    (scl_hz),
		.ADDR_BYTES(addr_bytes)
	) UUT (
		.clk    (clk),
		.rst_n  (rst_n),
		.awaddr (awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata  (wdata),
		.wvalid (wvalid),
		.wready (wready),
		.bvalid (bvalid),
		.bresp  (bresp),
		.bready (bready),
		.araddr (araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rvalid (rvalid),
		.rdata  (rdata),
		.rresp  (rresp),
		.rready (rready),
		.scl    (scl),
		.sda    (sda)
	);

	sccb_servant_model #(
		.ADDR_BYTES(addr_bytes),
		.DEV_ID    (dev_wr[7:1])
	) servant (
		.clk(clk),
		.scl(scl),
		.sda(sda)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	initial begin
		#(watchdog_ns);
		$display("watchdog expired after %0d ns, a test never finished", watchdog_ns);
		$display("Errors found");
		$finish;
	end

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_byte(output logic [7:0] b);
		b = 8'h00;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr); // one step per bit
			b    = {b[6:0], lfsr[0]};
		end
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
				   input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: %s is %h, expected %h", what, got, exp);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1; // inputs move just after the edge
	endtask

	task automatic axi_write(input logic [axi_addr_w-1:0] addr, input logic [31:0] data);
		next_cycle();
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		bready  = 1'b1;
		do
			next_cycle();
		while (!awready);
		check_value("wready", 32'(wready), 32'h1); // raised together with awready
		next_cycle(); // handshake edge
		awvalid = 1'b0;
		wvalid  = 1'b0;
		while (!bvalid)
			next_cycle();
		check_value("bresp", 32'(bresp), 32'h0);
		next_cycle(); // response taken
	endtask

	task automatic axi_read(input logic [axi_addr_w-1:0] addr, output logic [31:0] data);
		next_cycle();
		araddr  = addr;
		arvalid = 1'b1;
		rready  = 1'b1;
		do
			next_cycle();
		while (!arready);
		next_cycle();
		arvalid = 1'b0;
		while (!rvalid)
			next_cycle();
		data = rdata;
		check_value("rresp", 32'(rresp), 32'h0);
		next_cycle();
	endtask

	task automatic wait_for_count(input int n);
		logic [31:0] st;
		do
			axi_read(reg_status, st);
		while (st[status_count_lsb +: 8] < n);
	endtask

	task automatic wait_for_done(output logic [31:0] st);
		do
			axi_read(reg_status, st);
		while (!st[status_done_bit]);
	endtask

	// sends tx_bytes, next byte loaded while the current one is on the wire
	task automatic run_transaction(output logic [31:0] st);
		axi_write(reg_ctrl, 32'h1 << ctrl_clear_bit);
		axi_write(reg_txdata, tx_bytes[0]);
		axi_write(reg_ctrl, 32'h1 << ctrl_go_bit);
		axi_read(reg_status, st);
		check_value("status.busy", 32'(st[status_busy_bit]), 32'h1); // engine left idle
		check_value("status.done", 32'(st[status_done_bit]), 32'h0);
		for (int k = 1; k < tx_bytes.size(); k++) begin
			axi_write(reg_txdata, tx_bytes[k]);
			wait_for_count(k);
		end
		if (tx_bytes[0][0])
			wait_for_count(tx_bytes.size()); // reading, stop at the master ack
		axi_write(reg_ctrl, 32'h1 << ctrl_stop_bit);
		wait_for_done(st);
	endtask

	task automatic read_index(input logic [7:0] index, output logic [31:0] st);
		tx_bytes.delete();
		tx_bytes.push_back(dev_rd);
		for (int i = 0; i < addr_bytes - 1; i++)
			tx_bytes.push_back(8'h00);
		tx_bytes.push_back(index);
		run_transaction(st);
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (errors == errors_before)
			$display("%s: passed", name);
		else
			$display("%s: %0d mismatches", name, errors - errors_before);
	endtask

	task automatic test_reset_state();
		int          e0;
		logic [31:0] v;
		logic [31:0] word;
		logic [7:0]  b;
		e0 = errors;
		check_value("scl", 32'(scl), 32'h1); // bus idles high
		check_value("sda", 32'(sda), 32'h1);
		axi_read(reg_status, v);
		check_value("status", v, 32'h0);
		axi_read(reg_rxdata, v);
		check_value("rxdata.rx_valid", 32'(v[rx_valid_bit]), 32'h0);
		word = 32'h0;
		for (int i = 0; i < 4; i++) begin
			random_byte(b);
			word = {word[23:0], b};
		end
		axi_write(reg_txdata, word);
		axi_read(reg_txdata, v);
		check_value("txdata", v, {24'h0, word[7:0]});
		axi_read(4'h6, v);
		check_value("unmapped", v, 32'h0);
		report_test("test 1 reset and registers", e0);
	endtask

	task automatic test_write_transaction();
		int          e0;
		logic [31:0] st;
		e0 = errors;
		random_byte(wr_data);
		tx_bytes.delete();
		tx_bytes.push_back(dev_wr);
		for (int i = 0; i < addr_bytes - 1; i++)
			tx_bytes.push_back(8'h00);
		tx_bytes.push_back(8'h10);
		tx_bytes.push_back(wr_data);
		run_transaction(st);
		check_value("status.ack_count", 32'(st[status_count_lsb +: 8]), tx_bytes.size());
		check_value("status.nack", 32'(st[status_nack_bit]), 32'h0);
		check_value("status.busy", 32'(st[status_busy_bit]), 32'h0);
		check_value("scl", 32'(scl), 32'h1); // released after the stop
		check_value("sda", 32'(sda), 32'h1);
		report_test("test 2 write transaction", e0);
	endtask

	task automatic test_read_transaction();
		int          e0;
		logic [31:0] st;
		logic [31:0] v;
		e0 = errors;
		read_index(8'h10, st);
		check_value("status.ack_count", 32'(st[status_count_lsb +: 8]), 1 + addr_bytes);
		check_value("status.nack", 32'(st[status_nack_bit]), 32'h0);
		axi_read(reg_rxdata, v);
		check_value("rxdata", v, (32'h1 << rx_valid_bit) | wr_data);
		axi_read(reg_rxdata, v);
		check_value("rxdata", v, {24'h0, wr_data}); // valid popped by the first read
		read_index(8'h20, st);
		axi_read(reg_rxdata, v);
		check_value("rxdata", v, (32'h1 << rx_valid_bit) | (8'h20 ^ preload_key));
		report_test("test 3 read transaction", e0);
	endtask

	task automatic test_nack_and_clear();
		int          e0;
		logic [31:0] st;
		e0 = errors;
		axi_write(reg_ctrl, 32'h1 << ctrl_clear_bit);
		axi_write(reg_txdata, dev_none);
		axi_write(reg_ctrl, (32'h1 << ctrl_go_bit) | (32'h1 << ctrl_stop_bit));
		wait_for_done(st);
		check_value("status", st, (32'h1 << status_nack_bit) | (32'h1 << status_done_bit) |
			    (32'h1 << status_count_lsb));
		axi_write(reg_ctrl, 32'h1 << ctrl_clear_bit);
		axi_read(reg_status, st);
		check_value("status", st, 32'h0);
		report_test("test 4 nack and clear", e0);
	endtask

	task automatic test_back_pressure();
		int          e0;
		logic [7:0]  first_b;
		logic [7:0]  second_b;
		logic [31:0] v;
		e0 = errors;
		random_byte(first_b);
		random_byte(second_b);
		next_cycle();
		bready  = 1'b0;
		awaddr  = reg_txdata;
		wdata   = {24'h0, first_b};
		awvalid = 1'b1;
		wvalid  = 1'b1;
		do
			next_cycle();
		while (!awready);
		next_cycle();
		wdata = {24'h0, second_b}; // second write waits behind bvalid
		for (int i = 0; i < 10; i++) begin
			next_cycle();
			check_value("bvalid", 32'(bvalid), 32'h1);
			check_value("awready", 32'(awready), 32'h0);
		end
		bready = 1'b1;
		do
			next_cycle();
		while (!awready);
		next_cycle();
		awvalid = 1'b0;
		wvalid  = 1'b0;
		while (!bvalid)
			next_cycle();
		next_cycle();
		axi_read(reg_txdata, v);
		check_value("txdata", v, {24'h0, second_b});

		rready  = 1'b0;
		araddr  = reg_txdata;
		arvalid = 1'b1;
		do
			next_cycle();
		while (!arready);
		next_cycle();
		araddr = reg_status; // second read waits behind rvalid
		for (int i = 0; i < 10; i++) begin
			next_cycle();
			check_value("rvalid", 32'(rvalid), 32'h1);
			check_value("arready", 32'(arready), 32'h0);
			check_value("rdata", rdata, {24'h0, second_b});
		end
		rready = 1'b1;
		do
			next_cycle();
		while (!arready);
		next_cycle();
		arvalid = 1'b0;
		while (!rvalid)
			next_cycle();
		v = rdata;
		next_cycle();
		check_value("rdata", v, 32'h0);
		report_test("test 5 back-pressure", e0);
	endtask

	initial begin
		rst_n   = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wvalid  = 1'b0;
		bready  = 1'b1;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b1;
		errors  = 0;
		checks  = 0;
		wr_data = 8'h00;
		lfsr    = 32'hd5f6_9501;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;

		test_reset_state();
		test_write_transaction();
		test_read_transaction();
		test_nack_and_clear();
		test_back_pressure();

		$display("checks %0d, mismatches %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/sccb_byte_engine.sv
`timescale 1ns/1ps
`default_nettype none

module sccb_byte_engine #(
	parameter int CLK_HZ     = 50_000_000,
	parameter int SCL_HZ     = 100_000,
	parameter int ADDR_BYTES = 2
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       go,       // ignored unless idle
	input  logic [7:0] tx_byte,  // latched at go and at every ack
	input  logic       stop_req, // sampled once per acknowledge
	output logic       ack_tick,
	output logic       ack_ok,
	output logic       rd_tick,
	output logic [7:0] rd_byte,
	output logic       busy,
	output logic       scl,
	inout  wire        sda
);

	import sccb_pkg::*;

	localparam int half_cnt = CLK_HZ / (2 * SCL_HZ); // clocks per scl phase
	localparam int mid_cnt  = half_cnt / 2;
	localparam int cnt_w    = (half_cnt > 2) ? $clog2(half_cnt) : 1;
	localparam int ab_w     = $clog2(ADDR_BYTES + 2); // holds device byte plus address bytes

	engine_state_t   state_q;
	logic [cnt_w-1:0] cnt_q;     // position inside the current scl phase
	logic            scl_q;
	logic            sda_q;     // level driven when sda is not released
	logic            op_q;      // r/w bit of the device byte, 1 = read
	logic [3:0]      idx_q;     // bit index, 8..0 out, 7..0 in
	logic [8:0]      shift_q;   // byte plus a released ninth bit
	logic [7:0]      rd_q;
	logic [ab_w-1:0] ab_q;      // bytes still to go before read data, device byte included
	logic            hold_q;    // ninth bit done, waiting for scl to fall
	logic            stop_seen_q;
	logic            phase_end;
	logic            scl_hi;
	logic            scl_lo;
	logic            scl_fall;
	logic            release_sda;
	logic            sda_in;

	assign phase_end = (cnt_q == cnt_w'(half_cnt - 1));
	assign scl_hi    = scl_q && (cnt_q == cnt_w'(mid_cnt));  // middle of high phase
	assign scl_lo    = !scl_q && (cnt_q == cnt_w'(mid_cnt)); // middle of low phase
	assign scl_fall  = scl_q && phase_end && (state_q != idle);

	// servant owns sda while it sends data or its ack, up to the fall after its last bit
	assign release_sda = (state_q == read) || (state_q == ack_servant) ||
			     ((state_q == ack_master) && !hold_q);
	assign sda         = release_sda ? 1'bz : sda_q;
	assign sda_in      = sda;
	assign scl         = scl_q; // push-pull, no stretching

	assign busy    = (state_q != idle);
	assign rd_byte = rd_q;

	// scl divider, parked high and phase aligned while idle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt_q <= '0;
			scl_q <= 1'b1;
		end else if (state_q == idle) begin
			cnt_q <= '0;
			scl_q <= 1'b1;
		end else if (phase_end) begin
			cnt_q <= '0;
			scl_q <= ~scl_q;
		end else begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	// bit level FSM
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q     <= idle;
			sda_q       <= 1'b1;
			op_q        <= 1'b0;
			idx_q       <= 4'd0;
			ab_q        <= '0;
			hold_q      <= 1'b0;
			stop_seen_q <= 1'b0;
			ack_tick    <= 1'b0;
			ack_ok      <= 1'b0;
			rd_tick     <= 1'b0;
		end else begin
			ack_tick <= 1'b0;
			rd_tick  <= 1'b0;
			case (state_q)
				idle: begin
					sda_q  <= 1'b1;
					hold_q <= 1'b0;
					ab_q   <= ab_w'(ADDR_BYTES + 1);
					if (go) begin
						op_q    <= tx_byte[0]; // device byte r/w bit picks the direction
						idx_q   <= 4'd8;
						state_q <= starting;
					end
				end
				starting: begin
					if (scl_hi) begin
						sda_q   <= 1'b0; // start condition
						state_q <= packet;
					end
				end
				packet: begin
					if (scl_lo) begin
						sda_q <= shift_q[idx_q]; // msb first, bit 0 is the released slot
						if (idx_q == 4'd0)
							state_q <= ack_servant;
						else
							idx_q <= idx_q - 1'b1;
					end
				end
				ack_servant: begin
					if (scl_hi && !hold_q) begin
						ack_tick    <= 1'b1;
						ack_ok      <= ~sda_in; // low = ACK
						stop_seen_q <= stop_req;
						hold_q      <= 1'b1;
						if (ab_q != '0)
							ab_q <= ab_q - 1'b1;
					end else if (scl_fall && hold_q) begin
						hold_q <= 1'b0; // servant lets go of sda on this edge
						if (stop_seen_q) begin
							sda_q   <= 1'b0;
							state_q <= stop_1;
						end else if (op_q && (ab_q == '0)) begin
							idx_q   <= 4'd7; // address done, turn around
							state_q <= read;
						end else begin
							idx_q   <= 4'd8;
							state_q <= packet;
						end
					end
				end
				read: begin
					if (scl_hi) begin
						rd_q[idx_q[2:0]] <= sda_in;
						if (idx_q == 4'd0)
							state_q <= ack_master;
						else
							idx_q <= idx_q - 1'b1;
					end
				end
				ack_master: begin
					if (scl_lo && !hold_q) begin
						sda_q  <= 1'b0; // master ACK for every byte read
						hold_q <= 1'b1;
					end else if (scl_fall && hold_q) begin
						hold_q  <= 1'b0;
						rd_tick <= 1'b1;
						if (stop_req) begin
							state_q <= stop_1; // sda already low
						end else begin
							idx_q   <= 4'd7;
							state_q <= read;
						end
					end
				end
				stop_1: begin
					if (scl_lo) begin
						sda_q   <= 1'b0;
						state_q <= stop_2;
					end
				end
				stop_2: begin
					if (scl_hi) begin
						sda_q   <= 1'b1; // stop condition, bus free
						state_q <= idle;
					end
				end
				default: begin
					state_q <= idle;
				end
			endcase
		end
	end

	// outgoing byte, reloaded at go and at each servant ack
	always_ff @(posedge clk) begin
		if ((state_q == idle) && go)
			shift_q <= {tx_byte, 1'b1};
		else if ((state_q == ack_servant) && scl_hi && !hold_q)
			shift_q <= {tx_byte, 1'b1}; // software must have the next byte ready
	end

endmodule

`default_nettype wire

// File: src/sccb_master_top.sv
`timescale 1ns/1ps
`default_nettype none

module sccb_master_top #(
	parameter int CLK_HZ     = 50_000_000,
	parameter int SCL_HZ     = 100_000,
	parameter int ADDR_BYTES = 2
) (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [sccb_pkg::axi_addr_w-1:0] awaddr,
	input  logic                            awvalid,
	output logic                            awready,
	input  logic [sccb_pkg::axi_data_w-1:0] wdata,
	input  logic                            wvalid,
	output logic                            wready,
	output logic                            bvalid,
	output logic [1:0]                      bresp,
	input  logic                            bready,
	input  logic [sccb_pkg::axi_addr_w-1:0] araddr,
	input  logic                            arvalid,
	output logic                            arready,
	output logic                            rvalid,
	output logic [sccb_pkg::axi_data_w-1:0] rdata,
	output logic [1:0]                      rresp,
	input  logic                            rready,
	output logic                            scl,
	inout  wire                             sda
);

	logic       go;        // decode -> engine
	logic [7:0] tx_byte;
	logic       stop_req;
	logic       ack_tick;  // engine -> result
	logic       ack_ok;
	logic       rd_tick;
	logic [7:0] rd_byte;
	logic       busy;      // engine -> result and status
	logic       clear;     // decode -> result
	logic       rx_taken;
	logic [7:0] rx_byte;   // result -> decode
	logic       rx_valid;
	logic       done;
	logic       nack;
	logic [7:0] ack_count;

	sccb_regs_decode u_decode (
		.clk      (clk),
		.rst_n    (rst_n),
		.awaddr   (awaddr),
		.awvalid  (awvalid),
		.awready  (awready),
		.wdata    (wdata),
		.wvalid   (wvalid),
		.wready   (wready),
		.bvalid   (bvalid),
		.bresp    (bresp),
		.bready   (bready),
		.araddr   (araddr),
		.arvalid  (arvalid),
		.arready  (arready),
		.rvalid   (rvalid),
		.rdata    (rdata),
		.rresp    (rresp),
		.rready   (rready),
		.go       (go),
		.tx_byte  (tx_byte),
		.stop_req (stop_req),
		.clear    (clear),
		.rx_taken (rx_taken),
		.rx_byte  (rx_byte),
		.rx_valid (rx_valid),
		.busy     (busy),
		.done     (done),
		.nack     (nack),
		.ack_count(ack_count)
	);

	sccb_byte_engine #(
		.CLK_HZ    (CLK_HZ),
		.SCL_HZ    (SCL_HZ),
		.ADDR_BYTES(ADDR_BYTES)
	) u_engine (
		.clk     (clk),
		.rst_n   (rst_n),
		.go      (go),
		.tx_byte (tx_byte),
		.stop_req(stop_req),
		.ack_tick(ack_tick),
		.ack_ok  (ack_ok),
		.rd_tick (rd_tick),
		.rd_byte (rd_byte),
		.busy    (busy),
		.scl     (scl),
		.sda     (sda)
	);

	sccb_result u_result (
		.clk      (clk),
		.rst_n    (rst_n),
		.ack_tick (ack_tick),
		.ack_ok   (ack_ok),
		.rd_tick  (rd_tick),
		.rd_byte  (rd_byte),
		.busy     (busy),
		.clear    (clear),
		.rx_taken (rx_taken),
		.rx_byte  (rx_byte),
		.rx_valid (rx_valid),
		.done     (done),
		.nack     (nack),
		.ack_count(ack_count)
	);

endmodule

`default_nettype wire

// File: src/sccb_pkg.sv
`default_nettype none

package sccb_pkg;

	// bus geometry
	localparam int axi_addr_w = 4; // covers the four word registers
	localparam int axi_data_w = 32;

	// register byte offsets
	localparam logic [axi_addr_w-1:0] reg_ctrl   = 4'h0; // go, stop, clear
	localparam logic [axi_addr_w-1:0] reg_txdata = 4'h4; // next byte to send
	localparam logic [axi_addr_w-1:0] reg_rxdata = 4'h8; // last byte read + valid flag
	localparam logic [axi_addr_w-1:0] reg_status = 4'hc; // busy, done, nack, ack count

	// CTRL bits
	localparam int ctrl_go_bit    = 0; // start a transaction, self clearing
	localparam int ctrl_stop_bit  = 1; // stop after the current acknowledge
	localparam int ctrl_clear_bit = 8; // wipe done, nack and count

	// RXDATA / STATUS bits
	localparam int rx_valid_bit     = 8;
	localparam int status_busy_bit  = 0;
	localparam int status_done_bit  = 1;
	localparam int status_nack_bit  = 2;
	localparam int status_count_lsb = 8; // 8-bit ack count starts here

	// byte engine states
	typedef enum logic [3:0] {
		idle        = 4'd0, // bus released, scl held high
		starting    = 4'd1, // sda falls while scl high
		packet      = 4'd2, // shifting a byte out, msb first
		ack_servant = 4'd3, // ninth bit, servant answers
		read        = 4'd4, // shifting a byte in
		ack_master  = 4'd5, // master pulls sda low for the ninth bit
		stop_1      = 4'd6, // sda low under scl low
		stop_2      = 4'd7  // sda rises while scl high
	} engine_state_t;

endpackage

`default_nettype wire

// File: src/sccb_regs_decode.sv
`timescale 1ns/1ps
`default_nettype none

module sccb_regs_decode (
	input  logic                            clk,
	input  logic                            rst_n,
	// write address / data / response
	input  logic [sccb_pkg::axi_addr_w-1:0] awaddr,
	input  logic                            awvalid,
	output logic                            awready,
	input  logic [sccb_pkg::axi_data_w-1:0] wdata,
	input  logic                            wvalid,
	output logic                            wready,
	output logic                            bvalid,
	output logic [1:0]                      bresp,
	input  logic                            bready,
	// read address / data
	input  logic [sccb_pkg::axi_addr_w-1:0] araddr,
	input  logic                            arvalid,
	output logic                            arready,
	output logic                            rvalid,
	output logic [sccb_pkg::axi_data_w-1:0] rdata,
	output logic [1:0]                      rresp,
	input  logic                            rready,
	// to the byte engine
	output logic                            go,
	output logic [7:0]                      tx_byte,
	output logic                            stop_req,
	// to / from the result block
	output logic                            clear,
	output logic                            rx_taken,
	input  logic [7:0]                      rx_byte,
	input  logic                            rx_valid,
	input  logic                            busy,
	input  logic                            done,
	input  logic                            nack,
	input  logic [7:0]                      ack_count
);

	import sccb_pkg::*;

	logic                  aw_hs; // address and data accepted together
	logic                  ar_hs;
	logic                  wr_ctrl;
	logic [axi_data_w-1:0] rd_mux;

	assign aw_hs   = awvalid && awready && wvalid && wready;
	assign ar_hs   = arvalid && arready;
	assign wr_ctrl = aw_hs && (awaddr == reg_ctrl);

	assign bresp    = 2'b00; // always OKAY, unmapped writes just vanish
	assign rresp    = 2'b00;
	assign rx_taken = ar_hs && (araddr == reg_rxdata); // pop the rx flag on accept

	// write channel
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
		end else begin
			awready <= awvalid && wvalid && !bvalid && !awready; // one cycle ready pulse
			wready  <= awvalid && wvalid && !bvalid && !awready;
			if (aw_hs)
				bvalid <= 1'b1; // response one cycle after the handshake
			else if (bvalid && bready)
				bvalid <= 1'b0;
		end
	end

	// control / transmit registers and command pulses
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_byte  <= 8'h00;
			stop_req <= 1'b0;
			go       <= 1'b0;
			clear    <= 1'b0;
		end else begin
			go    <= wr_ctrl && wdata[ctrl_go_bit];    // lands in the engine next cycle
			clear <= wr_ctrl && wdata[ctrl_clear_bit];
			if (wr_ctrl)
				stop_req <= wdata[ctrl_stop_bit]; // level, sampled at each ack
			if (aw_hs && (awaddr == reg_txdata))
				tx_byte <= wdata[7:0]; // whole register replaced, no strobes
		end
	end

	// read data select by offset
	always_comb begin
		rd_mux = '0; // unmapped offsets read zero
		case (araddr)
			reg_ctrl: begin
				rd_mux[ctrl_stop_bit] = stop_req; // go and clear read back as zero
			end
			reg_txdata: begin
				rd_mux[7:0] = tx_byte;
			end
			reg_rxdata: begin
				rd_mux[7:0]          = rx_byte;
				rd_mux[rx_valid_bit] = rx_valid;
			end
			reg_status: begin
				rd_mux[status_busy_bit]            = busy;
				rd_mux[status_done_bit]            = done;
				rd_mux[status_nack_bit]            = nack;
				rd_mux[status_count_lsb +: 8]      = ack_count;
			end
			default: begin
			end
		endcase
	end

	// read channel
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end else begin
			arready <= arvalid && !rvalid && !arready; // held rvalid blocks new reads
			if (ar_hs)
				rvalid <= 1'b1;
			else if (rvalid && rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (ar_hs)
			rdata <= rd_mux; // captured at accept, stable while rvalid waits
	end

endmodule

`default_nettype wire

// File: src/sccb_result.sv
`timescale 1ns/1ps
`default_nettype none

module sccb_result (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       ack_tick,
	input  logic       ack_ok,
	input  logic       rd_tick,
	input  logic [7:0] rd_byte,
	input  logic       busy,
	input  logic       clear,    // wipes done, nack and count
	input  logic       rx_taken, // RXDATA read accepted
	output logic [7:0] rx_byte,
	output logic       rx_valid,
	output logic       done,
	output logic       nack,
	output logic [7:0] ack_count
);

	logic busy_q; // previous busy for edge detect

	// acknowledge bookkeeping and end of transaction
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_q    <= 1'b0;
			done      <= 1'b0;
			nack      <= 1'b0;
			ack_count <= 8'd0;
		end else begin
			busy_q <= busy;
			if (clear) begin
				done      <= 1'b0;
				nack      <= 1'b0;
				ack_count <= 8'd0;
			end
			if (busy_q && !busy)
				done <= 1'b1; // sticky until cleared
			if (ack_tick) begin
				if (ack_count != 8'hff)
					ack_count <= ack_count + 1'b1; // saturates
				if (!ack_ok)
					nack <= 1'b1; // any missed ack sticks
			end
		end
	end

	// received byte, one deep
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_byte  <= 8'h00;
			rx_valid <= 1'b0;
		end else if (rd_tick) begin
			rx_byte  <= rd_byte; // a new byte wins over a pop in the same cycle
			rx_valid <= 1'b1;
		end else if (rx_taken) begin
			rx_valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire
